//--- axi_lite_pkg.sv
package axi_lite_pkg;

  // --------------------
  // response codes
  // --------------------

  typedef logic [1:0] axi_resp_t;

  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;  // decoded but failed, e.g. out of range

  // --------------------
  // channel payloads
  // --------------------

  typedef logic [31:0] axi_addr_t;

  // write data channel
  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb;  // one bit per byte lane, bit 0 is the lowest byte
  } axi_w_t;

  // read data channel
  typedef struct packed {
    logic [31:0] data;
    axi_resp_t   resp;
  } axi_r_t;

endpackage

//--- lsu_pkg.sv
package lsu_pkg;

  // --------------------
  // core side
  // --------------------

  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } access_size_t;

  typedef struct packed {
    logic         write;  // store when set, load otherwise
    access_size_t size;
    logic         sext;   // sign-extend a narrow load
    logic [31:0]  addr;
    logic [31:0]  wsrc;   // store value, right aligned
  } lsu_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } lsu_result_t;

  // --------------------
  // internal ops
  // --------------------

  // what the load formatter needs to know about the access
  typedef struct packed {
    access_size_t size;
    logic         sext;
    logic [1:0]   offset;  // byte lane of the lowest accessed byte
  } load_fmt_t;

  typedef struct packed {
    logic                    write;
    axi_lite_pkg::axi_addr_t addr;
    axi_lite_pkg::axi_w_t    w;
    load_fmt_t               fmt;
  } bus_op_t;

endpackage

//--- lsu_request_stage.sv
`timescale 1ns/1ps

module lsu_request_stage (
  input  logic              clock,
  input  logic              reset,
  input  logic              req_valid,
  input  lsu_pkg::lsu_req_t req,
  input  logic              bus_done,
  output logic              op_valid,
  output lsu_pkg::bus_op_t  op
);

  import lsu_pkg::*;

  logic        busy;
  logic        accept;
  logic [1:0]  offset;
  logic [3:0]  strb_next;
  logic [31:0] data_next;

  assign accept = req_valid && !busy;  // a strobe seen while busy is simply lost
  assign offset = req.addr[1:0];

  // --------------------
  // store lane placement
  // --------------------

  always_comb begin
    strb_next = 4'b0000;  // loads carry no strobe and no data
    data_next = 32'h0;
    if (req.write) begin
      case (req.size)
        size_byte: begin
          strb_next = 4'b0001 << offset;
          data_next = req.wsrc << {offset, 3'b000};
        end
        size_half: begin
          strb_next = 4'b0011 << offset;
          data_next = req.wsrc << {offset, 3'b000};
        end
        size_word: begin
          strb_next = 4'b1111;
          data_next = req.wsrc;
        end
        default: begin
          strb_next = 4'b0000;
          data_next = 32'h0;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy     <= 1'b0;
      op_valid <= 1'b0;
    end else begin
      op_valid <= accept;
      if (accept) begin
        busy <= 1'b1;
      end else if (bus_done) begin
        busy <= 1'b0;  // bus side finished, next request may come in
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      op.write      <= req.write;
      op.addr       <= req.addr;
      op.w.data     <= data_next;
      op.w.strb     <= strb_next;
      op.fmt.size   <= req.size;
      op.fmt.sext   <= req.sext;
      op.fmt.offset <= offset;
    end
  end

endmodule

//--- lsu_bus_master.sv
`timescale 1ns/1ps

module lsu_bus_master (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    op_valid,
  input  lsu_pkg::bus_op_t        op,
  // read address
  output logic                    arvalid,
  output axi_lite_pkg::axi_addr_t araddr,
  input  logic                    arready,
  // read data
  input  logic                    rvalid,
  input  axi_lite_pkg::axi_r_t    r,
  output logic                    rready,
  // write address
  output logic                    awvalid,
  output axi_lite_pkg::axi_addr_t awaddr,
  input  logic                    awready,
  // write data
  output logic                    wvalid,
  output axi_lite_pkg::axi_w_t    w,
  input  logic                    wready,
  // write response
  input  logic                    bvalid,
  input  axi_lite_pkg::axi_resp_t bresp,
  output logic                    bready,
  // towards the load formatter
  output logic                    bus_done,
  output logic [31:0]             bus_rdata,
  output axi_lite_pkg::axi_resp_t bus_resp,
  output lsu_pkg::load_fmt_t      bus_fmt
);

  import lsu_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_read_addr,
    st_read_data,
    st_write_addr,
    st_write_data,
    st_write_resp
  } state_t;

  state_t  state;
  bus_op_t op_q;

  assign araddr  = op_q.addr;
  assign awaddr  = op_q.addr;
  assign w       = op_q.w;
  assign bus_fmt = op_q.fmt;

  // --------------------
  // channel sequencing
  // --------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= st_idle;
      arvalid  <= 1'b0;
      rready   <= 1'b0;
      awvalid  <= 1'b0;
      wvalid   <= 1'b0;
      bready   <= 1'b0;
      bus_done <= 1'b0;
    end else begin
      bus_done <= 1'b0;  // single-cycle strobe
      case (state)
        st_idle: begin
          if (op_valid && op.write) begin
            awvalid <= 1'b1;
            state   <= st_write_addr;
          end else if (op_valid) begin
            arvalid <= 1'b1;
            state   <= st_read_addr;
          end
        end
        st_read_addr: begin
          if (arready) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;
            state   <= st_read_data;
          end
        end
        st_read_data: begin
          if (rvalid) begin
            rready   <= 1'b0;
            bus_done <= 1'b1;
            state    <= st_idle;
          end
        end
        st_write_addr: begin
          if (awready) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b1;
            state   <= st_write_data;
          end
        end
        st_write_data: begin
          if (wready) begin
            wvalid <= 1'b0;
            bready <= 1'b1;
            state  <= st_write_resp;
          end
        end
        st_write_resp: begin
          if (bvalid) begin
            bready   <= 1'b0;
            bus_done <= 1'b1;
            state    <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // op and response payload
  always_ff @(posedge clock) begin
    if (state == st_idle && op_valid) begin
      op_q <= op;
    end
    if (state == st_read_data && rvalid) begin
      bus_rdata <= r.data;
      bus_resp  <= r.resp;
    end
    if (state == st_write_resp && bvalid) begin
      bus_rdata <= 32'h0;  // stores return no data
      bus_resp  <= bresp;
    end
  end

endmodule

//--- lsu_load_format.sv
`timescale 1ns/1ps

module lsu_load_format (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    bus_done,
  input  logic [31:0]             bus_rdata,
  input  axi_lite_pkg::axi_resp_t bus_resp,
  input  lsu_pkg::load_fmt_t      bus_fmt,
  output logic                    done,
  output lsu_pkg::lsu_result_t    result
);

  import axi_lite_pkg::*;
  import lsu_pkg::*;

  logic [31:0] shifted;
  logic [31:0] extended;

  assign shifted = bus_rdata >> {bus_fmt.offset, 3'b000};  // selected lane moves to bit 0

  always_comb begin
    case (bus_fmt.size)
      size_byte: begin
        extended = {{24{bus_fmt.sext & shifted[7]}}, shifted[7:0]};
      end
      size_half: begin
        extended = {{16{bus_fmt.sext & shifted[15]}}, shifted[15:0]};
      end
      size_word: begin
        extended = shifted;
      end
      default: begin
        extended = shifted;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= bus_done;
    end
  end

  always_ff @(posedge clock) begin
    if (bus_done) begin
      result.rdata <= extended;  // zero for stores since the bus data is zero
      result.err   <= (bus_resp == RESP_SLVERR);
    end
  end

endmodule

//--- axi_lite_sram.sv
`timescale 1ns/1ps

module axi_lite_sram #(
  parameter int MEM_WORDS   = 256,
  parameter int WAIT_CYCLES = 1
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    arvalid,
  input  axi_lite_pkg::axi_addr_t araddr,
  output logic                    arready,
  output logic                    rvalid,
  output axi_lite_pkg::axi_r_t    r,
  input  logic                    rready,
  input  logic                    awvalid,
  input  axi_lite_pkg::axi_addr_t awaddr,
  output logic                    awready,
  input  logic                    wvalid,
  input  axi_lite_pkg::axi_w_t    w,
  output logic                    wready,
  output logic                    bvalid,
  output axi_lite_pkg::axi_resp_t bresp,
  input  logic                    bready
);

  import axi_lite_pkg::*;

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;
  localparam logic [32:0] MEM_BYTES = 33'(MEM_WORDS) << 2;

  typedef enum logic [1:0] {st_idle, st_write_data, st_read_resp, st_write_resp} state_t;

  state_t           state;
  logic [CNT_W-1:0] wait_cnt;
  logic             wait_done;
  logic             counting;
  logic             phase_end;
  logic             rd_ok;
  logic             wr_ok;
  logic [IDX_W-1:0] wr_idx;
  logic [31:0]      mem [MEM_WORDS];

  assign wait_done = (wait_cnt == CNT_W'(WAIT_CYCLES));
  assign rd_ok     = ({1'b0, araddr} < MEM_BYTES);

  // --------------------
  // handshakes
  // --------------------

  assign arready = (state == st_idle) && arvalid && wait_done;
  assign awready = (state == st_idle) && awvalid && !arvalid && wait_done;  // reads win
  assign wready  = (state == st_write_data) && wvalid && wait_done;
  assign rvalid  = (state == st_read_resp) && wait_done;
  assign bvalid  = (state == st_write_resp) && wait_done;

  assign phase_end = (arvalid && arready) || (awvalid && awready) || (wvalid && wready) ||
                     (rvalid && rready) || (bvalid && bready);

  always_comb begin
    case (state)
      st_idle:       counting = arvalid || awvalid;
      st_write_data: counting = wvalid;
      default:       counting = 1'b1;  // response phases wait without a request
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= st_idle;
      wait_cnt <= '0;
    end else begin
      if (phase_end) begin
        wait_cnt <= '0;
      end else if (counting && !wait_done) begin
        wait_cnt <= wait_cnt + 1'b1;
      end
      case (state)
        st_idle: begin
          if (arvalid && arready) begin
            state <= st_read_resp;
          end else if (awvalid && awready) begin
            state <= st_write_data;
          end
        end
        st_write_data: begin
          if (wvalid && wready) begin
            state <= st_write_resp;
          end
        end
        st_read_resp: begin
          if (rready && rvalid) begin
            state <= st_idle;
          end
        end
        default: begin
          if (bready && bvalid) begin
            state <= st_idle;
          end
        end
      endcase
    end
  end

  // --------------------
  // storage
  // --------------------

  always_ff @(posedge clock) begin
    if (arvalid && arready) begin
      r.data <= rd_ok ? mem[araddr[IDX_W+1:2]] : 32'h0;
      r.resp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
    end
    if (awvalid && awready) begin
      wr_idx <= awaddr[IDX_W+1:2];
      wr_ok  <= ({1'b0, awaddr} < MEM_BYTES);
    end
    if (wvalid && wready) begin
      for (int i = 0; i < 4; i++) begin
        if (wr_ok && w.strb[i]) begin
          mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];  // only the strobed lanes change
        end
      end
      bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

endmodule

//--- lsu_subsystem.sv
`timescale 1ns/1ps

module lsu_subsystem #(
  parameter int MEM_WORDS   = 256,
  parameter int WAIT_CYCLES = 1
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 req_valid,
  input  lsu_pkg::lsu_req_t    req,
  output logic                 done,
  output lsu_pkg::lsu_result_t result
);

  import axi_lite_pkg::*;
  import lsu_pkg::*;

  logic      op_valid;
  bus_op_t   op;
  logic      bus_done;
  logic [31:0] bus_rdata;
  axi_resp_t bus_resp;
  load_fmt_t bus_fmt;

  // --------------------
  // axi-lite wires
  // --------------------

  logic      arvalid;
  axi_addr_t araddr;
  logic      arready;
  logic      rvalid;
  axi_r_t    r;
  logic      rready;
  logic      awvalid;
  axi_addr_t awaddr;
  logic      awready;
  logic      wvalid;
  axi_w_t    w;
  logic      wready;
  logic      bvalid;
  axi_resp_t bresp;
  logic      bready;

  lsu_request_stage u_request_stage (
    .clock, .reset, .req_valid, .req, .bus_done, .op_valid, .op
  );

  lsu_bus_master u_bus_master (
    .clock, .reset, .op_valid, .op,
    .arvalid, .araddr, .arready, .rvalid, .r, .rready,
    .awvalid, .awaddr, .awready, .wvalid, .w, .wready,
    .bvalid, .bresp, .bready,
    .bus_done, .bus_rdata, .bus_resp, .bus_fmt
  );

  lsu_load_format u_load_format (
    .clock, .reset, .bus_done, .bus_rdata, .bus_resp, .bus_fmt, .done, .result
  );

  axi_lite_sram #(
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_CYCLES (WAIT_CYCLES)
  ) u_sram (
    .clock, .reset,
    .arvalid, .araddr, .arready, .rvalid, .r, .rready,
    .awvalid, .awaddr, .awready, .wvalid, .w, .wready,
    .bvalid, .bresp, .bready
  );

endmodule

//--- tb_lsu_subsystem.sv
`timescale 1ns/1ps

module tb_lsu_subsystem;

  import lsu_pkg::*;

  localparam int MEM_WORDS   = 256;
  localparam int WAIT_CYCLES = 1;
  localparam int NUM_VECTORS = 22;
  localparam int VEC_FIELDS  = 7;
  localparam int CYCLE_LIMIT = NUM_VECTORS * (8 + 4 * WAIT_CYCLES) + 100;

  logic        clock = 1'b0;
  logic        reset;
  logic        req_valid;
  lsu_req_t    req;
  logic        done;
  lsu_result_t result;

  logic [31:0] vectors [NUM_VECTORS * VEC_FIELDS];  // seven words per access
  int          req_count      = 0;
  int          done_count     = 0;
  int          cycle_count    = 0;
  int          mismatch_count = 0;
  int          failure_count  = 0;

  lsu_subsystem #(
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_CYCLES (WAIT_CYCLES)
  ) u_lsu_subsystem (
    .clock, .reset, .req_valid, .req, .done, .result
  );

  always #4 clock = ~clock;

  // --------------------
  // watchdog and done monitor
  // --------------------

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the run did not finish", cycle_count);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  always @(posedge clock) begin
    if (!reset && done) begin
      assert (done_count < req_count) else begin
        $display("done strobe seen with no request outstanding (%0d requests, %0d dones)",
                 req_count, done_count);
        failure_count++;
      end
      done_count <= done_count + 1;
    end
  end

  // --------------------
  // request driving
  // --------------------

  task automatic issue_request(input int idx);
    int base;
    base = idx * VEC_FIELDS;
    @(posedge clock);
    req_valid <= 1'b1;
    req.write <= vectors[base][0];
    req.size  <= access_size_t'(vectors[base + 1][1:0]);
    req.sext  <= vectors[base + 2][0];
    req.addr  <= vectors[base + 3];
    req.wsrc  <= vectors[base + 4];
    req_count <= req_count + 1;
    @(posedge clock);
    req_valid <= 1'b0;  // strobe lasts one cycle
  endtask

  task automatic wait_for_done();
    while (!done) begin
      @(posedge clock);
    end
  endtask

  task automatic check_result(input int idx);
    logic [31:0] exp_rdata;
    logic        exp_err;
    exp_rdata = vectors[idx * VEC_FIELDS + 5];
    exp_err   = vectors[idx * VEC_FIELDS + 6][0];
    assert (done_count == req_count - 1) else begin
      $display("vector_%0d finished with %0d dones for %0d requests", idx, done_count + 1,
               req_count);
      failure_count++;
    end
    assert (result.rdata == exp_rdata) else begin
      $display("mismatch vector_%0d rdata expected %h actual %h", idx, exp_rdata,
               result.rdata);
      mismatch_count++;
    end
    assert (result.err == exp_err) else begin
      $display("mismatch vector_%0d err expected %b actual %b", idx, exp_err, result.err);
      mismatch_count++;
    end
  endtask

  // --------------------
  // main sequence
  // --------------------

  initial begin
    int gap;
    void'($urandom(32'h4f0b));
    reset     = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    $readmemh("lsu_testdata.hex", vectors);
    assert (!$isunknown(vectors[0])) else begin
      $display("test data in lsu_testdata.hex could not be read");
      failure_count++;
    end

    repeat (3) @(posedge clock);
    reset <= 1'b0;

    for (int i = 0; i < NUM_VECTORS; i++) begin
      gap = $urandom % 3;  // idle cycles before the next request
      repeat (gap) @(posedge clock);
      issue_request(i);
      wait_for_done();
      check_result(i);
    end

    repeat (20) @(posedge clock);  // late or extra dones show up here
    assert (done_count == req_count) else begin
      $display("saw %0d dones for %0d requests", done_count, req_count);
      failure_count++;
    end

    $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- lsu_testdata.hex
// each line holds write size sext addr wsrc expected_rdata expected_err in hex
// size is 0 for byte, 1 for half and 2 for word
1 2 0 00000010 12345678 00000000 0
0 2 0 00000010 00000000 12345678 0
1 0 0 00000020 DEADBEA1 00000000 0
1 0 0 00000021 DEADBEB2 00000000 0
1 0 0 00000022 DEADBEC3 00000000 0
1 0 0 00000023 DEADBE84 00000000 0
0 2 0 00000020 00000000 84C3B2A1 0
0 0 0 00000021 00000000 000000B2 0
0 0 1 00000021 00000000 FFFFFFB2 0
0 0 1 00000020 00000000 FFFFFFA1 0
0 0 1 00000023 00000000 FFFFFF84 0
0 1 0 00000022 00000000 000084C3 0
0 1 1 00000022 00000000 FFFF84C3 0
1 2 0 00000030 11223344 00000000 0
1 1 0 00000032 5555ABCD 00000000 0
0 2 0 00000030 00000000 ABCD3344 0
0 1 1 00000030 00000000 00003344 0
1 2 0 00000000 0BADC0DE 00000000 0
1 2 0 00000400 CAFEF00D 00000000 1
0 2 0 00000400 00000000 00000000 1
0 0 1 000007FC 00000000 00000000 1
0 2 0 00000000 00000000 0BADC0DE 0

//--- all.f
axi_lite_pkg.sv
lsu_pkg.sv
lsu_request_stage.sv
lsu_bus_master.sv
lsu_load_format.sv
axi_lite_sram.sv
lsu_subsystem.sv
tb_lsu_subsystem.sv
